// File: sources.f
design/qdq_pkg.sv
design/qdq_tile_ram.sv
design/qdq_tile_arbiter.sv
design/qdq_credit_counter.sv
design/qdq_quant_channel.sv
design/qdq_dequant_channel.sv
design/qdq_top.sv
sim/qdq_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module qdq_tb -f sources.f -Mdir obj_dir -o qdq_sim
	./obj_dir/qdq_sim | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/qdq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_tb;
  import qdq_pkg::*;

  localparam int NUM_CMDS = 6;
  localparam int WAIT_MAX = 1000;

  logic         clk;
  logic         rstnn;
  logic         q_cmd_valid;
  quant_cmd_t   q_cmd;
  logic         q_cmd_ready;
  logic         q_row_valid;
  act_row_t     q_row;
  logic         q_row_credit;
  logic         q_out_valid;
  logic         q_out_last;
  qint_row_t    q_out_row;
  logic         q_out_credit = 1'b0;
  logic         dq_cmd_valid;
  dequant_cmd_t dq_cmd;
  logic         dq_cmd_ready;
  logic         dq_row_valid;
  acc_row_t     dq_row;
  logic         dq_row_credit;
  logic         dq_out_valid;
  logic         dq_out_last;
  deq_row_t     dq_out_row;
  logic         dq_out_credit = 1'b0;
  logic         op_finish;

  integer       seed = 32'hfa2e_b0d1;
  int           errors = 0;
  bit           slow_credit = 1'b0;
  int           in_credit [2];
  int           rows_sent [2];
  int           credits_seen [2];
  int           rows_out [2];
  int           outstanding [2];

  quant_cmd_t   q_cmds [NUM_CMDS];
  dequant_cmd_t dq_cmds [NUM_CMDS];
  act_row_t     q_rows [NUM_CMDS*TILE_ROWS];
  acc_row_t     dq_rows [NUM_CMDS*TILE_ROWS];
  logic [63:0]  q_exp [$];
  logic [63:0]  dq_exp [$];

  qdq_top dut (
    .clk(clk), .rstnn(rstnn),
    .q_cmd_valid_i(q_cmd_valid), .q_cmd_i(q_cmd), .q_cmd_ready_o(q_cmd_ready),
    .q_row_valid_i(q_row_valid), .q_row_i(q_row), .q_row_credit_o(q_row_credit),
    .q_out_valid_o(q_out_valid), .q_out_last_o(q_out_last), .q_out_row_o(q_out_row),
    .q_out_credit_i(q_out_credit),
    .dq_cmd_valid_i(dq_cmd_valid), .dq_cmd_i(dq_cmd), .dq_cmd_ready_o(dq_cmd_ready),
    .dq_row_valid_i(dq_row_valid), .dq_row_i(dq_row), .dq_row_credit_o(dq_row_credit),
    .dq_out_valid_o(dq_out_valid), .dq_out_last_o(dq_out_last), .dq_out_row_o(dq_out_row),
    .dq_out_credit_i(dq_out_credit),
    .op_finish_o(op_finish)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Divide by 2^sh, rounding half up
  function automatic longint round_shift(input longint v, input int sh);
    if (sh == 0) begin
      return v;
    end
    return (v + (longint'(1) << (sh - 1))) >>> sh;
  endfunction

  function automatic longint saturate(input longint v, input longint lo, input longint hi);
    if (v > hi) begin
      return hi;
    end
    if (v < lo) begin
      return lo;
    end
    return v;
  endfunction

  function automatic qint_t quant_model(input act_t x, input shift_t sh);
    return qint_t'(saturate(round_shift(longint'(x), int'(sh)), -128, 127));
  endfunction

  function automatic deq_t dequant_model(input acc_t x, input scale_t sc, input shift_t sh);
    longint p;
    p = longint'(x) * longint'(sc);
    return deq_t'(saturate(round_shift(p, int'(sh)), -32768, 32767));
  endfunction

  // --------------------------------------------------
  // Checks and failure handling
  // --------------------------------------------------
  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout at %0t: %s", $time, why);
    $display("Errors before timeout: %0d", errors);
    $display("Test failed");
    $finish;
  endtask

  function automatic bit credit_roll();
    if (slow_credit) begin
      return ($random(seed) & 7) == 0;
    end
    return ($random(seed) & 1) == 0;
  endfunction

  // --------------------------------------------------
  // Stimulus and expected rows, built up front
  // --------------------------------------------------
  task automatic make_stimulus();
    acc_t      a;
    qint_row_t qe;
    deq_row_t  de;
    int        idx;
    for (int c = 0; c < NUM_CMDS; c++) begin
      q_cmds[c].shift  = shift_t'($random(seed) & 15);
      dq_cmds[c].scale = scale_t'($random(seed));
      dq_cmds[c].shift = shift_t'($random(seed));
      // Full scale, no shift, values near both limits
      if (c == 1) begin
        dq_cmds[c] = '{scale: 8'd255, shift: '0};
      end
      for (int r = 0; r < TILE_ROWS; r++) begin
        idx = c * TILE_ROWS + r;
        for (int e = 0; e < ROW_ELEMS; e++) begin
          q_rows[idx][e] = act_t'($random(seed));
          a = acc_t'($random(seed));
          a = a >>> (($random(seed) & 3) * 8);
          if (c == 1) begin
            case (e)
              0: a = 32'sh7fff_ffff;
              1: a = acc_t'(32'h8000_0000);
              2: a = acc_t'(129 + r);
              default: a = acc_t'(-128 - r);
            endcase
          end
          dq_rows[idx][e] = a;
          qe[e] = quant_model(q_rows[idx][e], q_cmds[c].shift);
          de[e] = dequant_model(a, dq_cmds[c].scale, dq_cmds[c].shift);
        end
        q_exp.push_back(64'(qe));
        dq_exp.push_back(de);
      end
    end
  endtask

  // --------------------------------------------------
  // Channel driver
  // --------------------------------------------------
  task automatic send_row(input int ch, input int idx);
    if (ch == 0) begin
      q_row_valid = 1'b1;
      q_row = q_rows[idx];
    end else begin
      dq_row_valid = 1'b1;
      dq_row = dq_rows[idx];
    end
  endtask

  task automatic run_channel(input int ch, input int c);
    int   sent;
    int   cyc;
    bit   done;
    logic ready;
    sent = 0;
    cyc = 0;
    done = 1'b0;
    ready = (ch == 0) ? q_cmd_ready : dq_cmd_ready;
    while (!ready) begin
      @(negedge clk);
      ready = (ch == 0) ? q_cmd_ready : dq_cmd_ready;
      cyc++;
      if (cyc > WAIT_MAX) begin
        abort_run("command ready never came back");
      end
    end
    if (ch == 0) begin
      q_cmd_valid = 1'b1;
      q_cmd = q_cmds[c];
    end else begin
      dq_cmd_valid = 1'b1;
      dq_cmd = dq_cmds[c];
    end
    cyc = 0;
    while (!done) begin
      @(negedge clk);
      cyc++;
      if (cyc == 1) begin
        check_equal(op_finish, 1'b0, "op_finish after command accept");
      end
      if (ch == 0) begin
        q_cmd_valid = 1'b0;
        q_row_valid = 1'b0;
        in_credit[0] += int'(q_row_credit);
        done = q_out_valid && q_out_last;
      end else begin
        dq_cmd_valid = 1'b0;
        dq_row_valid = 1'b0;
        in_credit[1] += int'(dq_row_credit);
        done = dq_out_valid && dq_out_last;
      end
      // A credit back means the slot frees at this edge
      if (sent < TILE_ROWS && in_credit[ch] > 0) begin
        send_row(ch, c * TILE_ROWS + sent);
        in_credit[ch]--;
        sent++;
        rows_sent[ch]++;
      end
      if (cyc > WAIT_MAX) begin
        abort_run("channel did not finish its tile");
      end
    end
    check_equal(in_credit[ch], 1, "input credit held after tile");
  endtask

  task automatic finish_check();
    @(negedge clk);
    check_equal(op_finish, 1'b1, "op_finish after last rows");
  endtask

  task automatic run_both(input int c);
    fork
      run_channel(0, c);
      run_channel(1, c);
    join
    finish_check();
  endtask

  // --------------------------------------------------
  // Output monitor and output credit return
  // --------------------------------------------------
  task automatic take_row(input int ch, input logic [63:0] got, input logic last);
    logic [63:0] exp;
    string       name;
    name = (ch == 0) ? "quantize" : "dequantize";
    if (ch == 0 && q_exp.size() > 0) begin
      exp = q_exp.pop_front();
    end else if (ch == 1 && dq_exp.size() > 0) begin
      exp = dq_exp.pop_front();
    end else begin
      errors++;
      $display("Unexpected %s output row at %0t", name, $time);
      return;
    end
    check_equal(got, exp, {name, " row"});
    check_equal(last, (rows_out[ch] % TILE_ROWS) == TILE_ROWS - 1, {name, " last flag"});
    rows_out[ch]++;
    outstanding[ch]++;
    check_equal(outstanding[ch] <= OUT_CREDITS, 1'b1, {name, " rows outstanding"});
  endtask

  always @(negedge clk) begin
    if (rstnn) begin
      credits_seen[0] += int'(q_row_credit);
      credits_seen[1] += int'(dq_row_credit);
      // Only rows taken at earlier edges are credited
      q_out_credit = 1'b0;
      dq_out_credit = 1'b0;
      if (outstanding[0] > 0 && credit_roll()) begin
        q_out_credit = 1'b1;
        outstanding[0]--;
      end
      if (outstanding[1] > 0 && credit_roll()) begin
        dq_out_credit = 1'b1;
        outstanding[1]--;
      end
      if (q_out_valid) begin
        take_row(0, 64'(q_out_row), q_out_last);
      end
      if (dq_out_valid) begin
        take_row(1, dq_out_row, dq_out_last);
      end
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rstnn = 1'b0;
    q_cmd_valid = 1'b0;
    q_cmd = '0;
    q_row_valid = 1'b0;
    q_row = '0;
    dq_cmd_valid = 1'b0;
    dq_cmd = '0;
    dq_row_valid = 1'b0;
    dq_row = '0;
    for (int ch = 0; ch < 2; ch++) begin
      in_credit[ch] = 1;
      rows_sent[ch] = 0;
      credits_seen[ch] = 0;
      rows_out[ch] = 0;
      outstanding[ch] = 0;
    end
    make_stimulus();
    repeat (10) @(negedge clk);
    rstnn = 1'b1;
    @(negedge clk);
    check_equal(q_cmd_ready, 1'b1, "quantize ready after reset");
    check_equal(dq_cmd_ready, 1'b1, "dequantize ready after reset");
    check_equal(q_out_valid, 1'b0, "quantize valid after reset");
    check_equal(dq_out_valid, 1'b0, "dequantize valid after reset");
    check_equal(op_finish, 1'b1, "op_finish after reset");

    // Each channel alone, then both sharing the buffer
    for (int c = 0; c < 2; c++) begin
      run_channel(0, c);
      finish_check();
    end
    for (int c = 0; c < 2; c++) begin
      run_channel(1, c);
      finish_check();
    end
    run_both(2);
    run_both(3);

    // Late output credits
    @(posedge clk);
    slow_credit = 1'b1;
    @(negedge clk);
    run_both(4);
    run_both(5);

    for (int ch = 0; ch < 2; ch++) begin
      check_equal(rows_sent[ch], TILE_ROWS * NUM_CMDS, "input rows sent");
      check_equal(credits_seen[ch], rows_sent[ch], "input credit returns");
      check_equal(rows_out[ch], TILE_ROWS * NUM_CMDS, "output rows received");
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/qdq_top.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_top (
  input  wire                        clk,
  input  wire                        rstnn,
  // Quantize channel
  input  wire                        q_cmd_valid_i,
  input  wire qdq_pkg::quant_cmd_t   q_cmd_i,
  output logic                       q_cmd_ready_o,
  input  wire                        q_row_valid_i,
  input  wire qdq_pkg::act_row_t     q_row_i,
  output logic                       q_row_credit_o,
  output logic                       q_out_valid_o,
  output logic                       q_out_last_o,
  output qdq_pkg::qint_row_t         q_out_row_o,
  input  wire                        q_out_credit_i,
  // Dequantize channel
  input  wire                        dq_cmd_valid_i,
  input  wire qdq_pkg::dequant_cmd_t dq_cmd_i,
  output logic                       dq_cmd_ready_o,
  input  wire                        dq_row_valid_i,
  input  wire qdq_pkg::acc_row_t     dq_row_i,
  output logic                       dq_row_credit_o,
  output logic                       dq_out_valid_o,
  output logic                       dq_out_last_o,
  output qdq_pkg::deq_row_t          dq_out_row_o,
  input  wire                        dq_out_credit_i,
  output logic                       op_finish_o
);
  import qdq_pkg::*;

  logic       q_has_credit;
  logic       dq_has_credit;
  logic       q_req_valid;
  logic       dq_req_valid;
  tile_req_t  q_req;
  tile_req_t  dq_req;
  logic       q_grant;
  logic       dq_grant;
  logic       q_rdata_valid;
  logic       dq_rdata_valid;
  tile_word_t arb_rdata;
  logic       ram_req_valid;
  tile_req_t  ram_req;
  tile_word_t ram_rdata;
  logic       q_busy;
  logic       dq_busy;

  // ------------------------------------------------
  // Output credits, spent on each row sent
  // ------------------------------------------------
  qdq_credit_counter u_q_credit (
    .clk(clk), .rstnn(rstnn),
    .spend_i(q_out_valid_o), .return_i(q_out_credit_i), .has_credit_o(q_has_credit)
  );

  qdq_credit_counter u_dq_credit (
    .clk(clk), .rstnn(rstnn),
    .spend_i(dq_out_valid_o), .return_i(dq_out_credit_i), .has_credit_o(dq_has_credit)
  );

  // ------------------------------------------------
  // Channels
  // ------------------------------------------------
  qdq_quant_channel u_quant (
    .clk(clk), .rstnn(rstnn),
    .cmd_valid_i(q_cmd_valid_i), .cmd_i(q_cmd_i), .cmd_ready_o(q_cmd_ready_o),
    .row_valid_i(q_row_valid_i), .row_i(q_row_i), .row_credit_o(q_row_credit_o),
    .tile_req_valid_o(q_req_valid), .tile_req_o(q_req), .tile_grant_i(q_grant),
    .tile_rdata_valid_i(q_rdata_valid), .tile_rdata_i(arb_rdata),
    .has_credit_i(q_has_credit),
    .out_valid_o(q_out_valid_o), .out_last_o(q_out_last_o), .out_row_o(q_out_row_o),
    .busy_o(q_busy)
  );

  qdq_dequant_channel u_dequant (
    .clk(clk), .rstnn(rstnn),
    .cmd_valid_i(dq_cmd_valid_i), .cmd_i(dq_cmd_i), .cmd_ready_o(dq_cmd_ready_o),
    .row_valid_i(dq_row_valid_i), .row_i(dq_row_i), .row_credit_o(dq_row_credit_o),
    .tile_req_valid_o(dq_req_valid), .tile_req_o(dq_req), .tile_grant_i(dq_grant),
    .tile_rdata_valid_i(dq_rdata_valid), .tile_rdata_i(arb_rdata),
    .has_credit_i(dq_has_credit),
    .out_valid_o(dq_out_valid_o), .out_last_o(dq_out_last_o), .out_row_o(dq_out_row_o),
    .busy_o(dq_busy)
  );

  // ------------------------------------------------
  // Shared tile buffer
  // ------------------------------------------------
  qdq_tile_arbiter u_arbiter (
    .clk(clk), .rstnn(rstnn),
    .q_req_valid_i(q_req_valid), .q_req_i(q_req),
    .dq_req_valid_i(dq_req_valid), .dq_req_i(dq_req),
    .q_grant_o(q_grant), .dq_grant_o(dq_grant),
    .ram_req_valid_o(ram_req_valid), .ram_req_o(ram_req), .ram_rdata_i(ram_rdata),
    .q_rdata_valid_o(q_rdata_valid), .dq_rdata_valid_o(dq_rdata_valid),
    .rdata_o(arb_rdata)
  );

  qdq_tile_ram u_ram (
    .clk(clk),
    .req_valid_i(ram_req_valid),
    .req_i(ram_req),
    .rdata_o(ram_rdata)
  );

  // Finished once both channels sit in IDLE
  assign op_finish_o = ~(q_busy | dq_busy);

endmodule

`default_nettype wire

// File: design/qdq_dequant_channel.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_dequant_channel (
  input  wire                        clk,
  input  wire                        rstnn,
  input  wire                        cmd_valid_i,
  input  wire qdq_pkg::dequant_cmd_t cmd_i,
  output logic                       cmd_ready_o,
  input  wire                        row_valid_i,
  input  wire qdq_pkg::acc_row_t     row_i,
  output logic                       row_credit_o,
  output logic                       tile_req_valid_o,
  output qdq_pkg::tile_req_t         tile_req_o,
  input  wire                        tile_grant_i,
  input  wire                        tile_rdata_valid_i,
  input  wire qdq_pkg::tile_word_t   tile_rdata_i,
  input  wire                        has_credit_i,
  output logic                       out_valid_o,
  output logic                       out_last_o,
  output qdq_pkg::deq_row_t          out_row_o,
  output logic                       busy_o
);
  import qdq_pkg::*;

  chan_state_t  state_q;
  row_idx_t     row_cnt_q;
  dequant_cmd_t cmd_q;
  logic         slot_valid_q;
  acc_row_t     slot_row_q;
  deq_row_t     conv_row;
  logic         grant_wr;
  logic         grant_rd;

  // Scale first, then rounding shift and int16 saturation
  function automatic deq_t dequantize(input acc_t x, input scale_t sc, input shift_t sh);
    logic signed [40:0] p;
    logic signed [42:0] t;
    p = x * $signed({1'b0, sc});
    t = ($signed({p, 1'b0}) >>> sh) + 43'sd1;
    t = t >>> 1;
    if (t > 43'sd32767) begin
      return 16'h7fff;
    end else if (t < -43'sd32768) begin
      return 16'h8000;
    end
    return t[15:0];
  endfunction

  always_comb begin
    for (int i = 0; i < ROW_ELEMS; i++) begin
      conv_row[i] = dequantize(slot_row_q[i], cmd_q.scale, cmd_q.shift);
    end
  end

  // ------------------------------------------------
  // Tile buffer requests
  // ------------------------------------------------
  assign grant_wr = tile_grant_i & (state_q == LOAD);
  assign grant_rd = tile_grant_i & (state_q == DRAIN);

  assign tile_req_valid_o = (state_q == LOAD) ? slot_valid_q :
                            (state_q == DRAIN) & has_credit_i & ~tile_rdata_valid_i;

  // Upper half of the buffer
  assign tile_req_o = '{
    we:    (state_q == LOAD),
    addr:  tile_addr_t'(TILE_ROWS) + tile_addr_t'(row_cnt_q),
    wdata: conv_row
  };

  assign row_credit_o = grant_wr;
  assign cmd_ready_o  = (state_q == IDLE);
  assign busy_o       = (state_q != IDLE);
  assign out_valid_o  = tile_rdata_valid_i;
  assign out_last_o   = tile_rdata_valid_i & (state_q == WAIT_LAST);
  assign out_row_o    = tile_rdata_i;

  // ------------------------------------------------
  // Command FSM and row slot
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state_q      <= IDLE;
      row_cnt_q    <= '0;
      slot_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_valid_i) begin
            state_q   <= LOAD;
            row_cnt_q <= '0;
          end
        end
        LOAD: begin
          if (grant_wr) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            if (row_cnt_q == LAST_ROW) begin
              state_q <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (grant_rd) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            if (row_cnt_q == LAST_ROW) begin
              state_q <= WAIT_LAST;
            end
          end
        end
        WAIT_LAST: begin
          // last row returns the cycle after the final read
          if (tile_rdata_valid_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (row_valid_i) begin
        slot_valid_q <= 1'b1;
      end else if (grant_wr) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid_i) begin
      slot_row_q <= row_i;
    end
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
  end

  a_row_in_load: assert property (@(posedge clk) disable iff (!rstnn)
    row_valid_i |-> state_q == LOAD);

  a_slot_free: assert property (@(posedge clk) disable iff (!rstnn)
    row_valid_i && slot_valid_q |-> grant_wr);

endmodule

`default_nettype wire

// File: design/qdq_quant_channel.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_quant_channel (
  input  wire                      clk,
  input  wire                      rstnn,
  input  wire                      cmd_valid_i,
  input  wire qdq_pkg::quant_cmd_t cmd_i,
  output logic                     cmd_ready_o,
  input  wire                      row_valid_i,
  input  wire qdq_pkg::act_row_t   row_i,
  output logic                     row_credit_o,
  output logic                     tile_req_valid_o,
  output qdq_pkg::tile_req_t       tile_req_o,
  input  wire                      tile_grant_i,
  input  wire                      tile_rdata_valid_i,
  input  wire qdq_pkg::tile_word_t tile_rdata_i,
  input  wire                      has_credit_i,
  output logic                     out_valid_o,
  output logic                     out_last_o,
  output qdq_pkg::qint_row_t       out_row_o,
  output logic                     busy_o
);
  import qdq_pkg::*;

  chan_state_t state_q;
  row_idx_t    row_cnt_q;
  shift_t      shift_q;
  logic        slot_valid_q;
  act_row_t    slot_row_q;
  qint_row_t   conv_row;
  logic        grant_wr;
  logic        grant_rd;

  // Arithmetic shift, round half up, saturate to int8
  function automatic qint_t quantize(input act_t x, input shift_t sh);
    logic signed [17:0] t;
    t = ($signed({x, 1'b0}) >>> sh) + 18'sd1;
    t = t >>> 1;
    if (t > 18'sd127) begin
      return 8'h7f;
    end else if (t < -18'sd128) begin
      return 8'h80;
    end
    return t[7:0];
  endfunction

  always_comb begin
    for (int i = 0; i < ROW_ELEMS; i++) begin
      conv_row[i] = quantize(slot_row_q[i], shift_q);
    end
  end

  // ------------------------------------------------
  // Tile buffer requests
  // ------------------------------------------------
  assign grant_wr = tile_grant_i & (state_q == LOAD);
  assign grant_rd = tile_grant_i & (state_q == DRAIN);

  // One read in flight at a time, so a held credit covers it
  assign tile_req_valid_o = (state_q == LOAD) ? slot_valid_q :
                            (state_q == DRAIN) & has_credit_i & ~tile_rdata_valid_i;

  // Lower half of the buffer
  assign tile_req_o = '{
    we:    (state_q == LOAD),
    addr:  tile_addr_t'(row_cnt_q),
    wdata: {{(WORD_W - $bits(qint_row_t)){1'b0}}, conv_row}
  };

  assign row_credit_o = grant_wr;
  assign cmd_ready_o  = (state_q == IDLE);
  assign busy_o       = (state_q != IDLE);
  assign out_valid_o  = tile_rdata_valid_i;
  assign out_last_o   = tile_rdata_valid_i & (state_q == WAIT_LAST);
  assign out_row_o    = tile_rdata_i[$bits(qint_row_t)-1:0];

  // ------------------------------------------------
  // Command FSM and row slot
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state_q      <= IDLE;
      row_cnt_q    <= '0;
      slot_valid_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_valid_i) begin
            state_q   <= LOAD;
            row_cnt_q <= '0;
          end
        end
        LOAD: begin
          if (grant_wr) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            if (row_cnt_q == LAST_ROW) begin
              state_q <= DRAIN;
            end
          end
        end
        DRAIN: begin
          if (grant_rd) begin
            row_cnt_q <= row_cnt_q + 1'b1;
            if (row_cnt_q == LAST_ROW) begin
              state_q <= WAIT_LAST;
            end
          end
        end
        WAIT_LAST: begin
          if (tile_rdata_valid_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      // A new row may land as the old one is written
      if (row_valid_i) begin
        slot_valid_q <= 1'b1;
      end else if (grant_wr) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid_i) begin
      slot_row_q <= row_i;
    end
    if (cmd_valid_i && cmd_ready_o) begin
      shift_q <= cmd_i.shift;
    end
  end

  a_row_in_load: assert property (@(posedge clk) disable iff (!rstnn)
    row_valid_i |-> state_q == LOAD);

  // Input credit keeps the slot from being overwritten
  a_slot_free: assert property (@(posedge clk) disable iff (!rstnn)
    row_valid_i && slot_valid_q |-> grant_wr);

endmodule

`default_nettype wire

// File: design/qdq_credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_credit_counter (
  input  wire  clk,
  input  wire  rstnn,
  input  wire  spend_i,
  input  wire  return_i,
  output logic has_credit_o
);
  import qdq_pkg::*;

  credit_t count_q;

  // Spend and return may land in the same cycle
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      count_q <= CREDIT_MAX;
    end else begin
      count_q <= count_q + credit_t'(return_i) - credit_t'(spend_i);
    end
  end

  assign has_credit_o = (count_q != '0);

  a_no_underflow: assert property (@(posedge clk) disable iff (!rstnn)
    spend_i |-> count_q != '0);

  // Sink never returns more credits than it was given
  a_no_overflow: assert property (@(posedge clk) disable iff (!rstnn)
    return_i |-> count_q != CREDIT_MAX);

endmodule

`default_nettype wire

// File: design/qdq_tile_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_tile_arbiter (
  input  wire                      clk,
  input  wire                      rstnn,
  input  wire                      q_req_valid_i,
  input  wire qdq_pkg::tile_req_t  q_req_i,
  input  wire                      dq_req_valid_i,
  input  wire qdq_pkg::tile_req_t  dq_req_i,
  output logic                     q_grant_o,
  output logic                     dq_grant_o,
  output logic                     ram_req_valid_o,
  output qdq_pkg::tile_req_t       ram_req_o,
  input  wire qdq_pkg::tile_word_t ram_rdata_i,
  output logic                     q_rdata_valid_o,
  output logic                     dq_rdata_valid_o,
  output qdq_pkg::tile_word_t      rdata_o
);

  // Set when the quantize side won the latest grant
  logic last_q_q;
  logic q_rd_q;
  logic dq_rd_q;

  // Round robin, quantize first after reset
  assign q_grant_o  = q_req_valid_i & (~dq_req_valid_i | ~last_q_q);
  assign dq_grant_o = dq_req_valid_i & (~q_req_valid_i | last_q_q);

  assign ram_req_valid_o = q_grant_o | dq_grant_o;
  assign ram_req_o       = q_grant_o ? q_req_i : dq_req_i;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      last_q_q <= 1'b0;
      q_rd_q   <= 1'b0;
      dq_rd_q  <= 1'b0;
    end else begin
      if (ram_req_valid_o) begin
        last_q_q <= q_grant_o;
      end
      // Tag the read data returning next cycle
      q_rd_q  <= q_grant_o & ~q_req_i.we;
      dq_rd_q <= dq_grant_o & ~dq_req_i.we;
    end
  end

  assign q_rdata_valid_o  = q_rd_q;
  assign dq_rdata_valid_o = dq_rd_q;
  assign rdata_o          = ram_rdata_i;

  a_one_grant: assert property (@(posedge clk) disable iff (!rstnn)
    !(q_grant_o && dq_grant_o));

endmodule

`default_nettype wire

// File: design/qdq_tile_ram.sv
`timescale 1ns/1ps
`default_nettype none

module qdq_tile_ram (
  input  wire                     clk,
  input  wire                     req_valid_i,
  input  wire qdq_pkg::tile_req_t req_i,
  output qdq_pkg::tile_word_t     rdata_o
);
  import qdq_pkg::*;

  // Lower half for quantize rows, upper half for dequantize rows
  tile_word_t mem [2*TILE_ROWS];

  // Single port, read data registered
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      if (req_i.we) begin
        mem[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_o <= mem[req_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/qdq_pkg.sv
`default_nettype none

package qdq_pkg;

  // ------------------------------------------------
  // Tile geometry and widths
  // ------------------------------------------------
  localparam int TILE_ROWS   = 4;
  localparam int ROW_ELEMS   = 4;
  localparam int TILE_ADDR_W = $clog2(2 * TILE_ROWS);
  localparam int SHIFT_W     = 5;
  localparam int OUT_CREDITS = 2;
  localparam int WORD_W      = 64;

  typedef logic [$clog2(TILE_ROWS)-1:0]     row_idx_t;
  typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_t;
  typedef logic [SHIFT_W-1:0]               shift_t;

  localparam row_idx_t LAST_ROW   = row_idx_t'(TILE_ROWS - 1);
  localparam credit_t  CREDIT_MAX = credit_t'(OUT_CREDITS);

  // ------------------------------------------------
  // Element and row types
  // ------------------------------------------------
  typedef logic signed [15:0] act_t;
  typedef logic signed [7:0]  qint_t;
  typedef logic signed [31:0] acc_t;
  typedef logic        [7:0]  scale_t;
  typedef logic signed [15:0] deq_t;

  typedef act_t  [ROW_ELEMS-1:0] act_row_t;
  typedef qint_t [ROW_ELEMS-1:0] qint_row_t;
  typedef acc_t  [ROW_ELEMS-1:0] acc_row_t;
  typedef deq_t  [ROW_ELEMS-1:0] deq_row_t;

  // Holds either output row type
  typedef logic [WORD_W-1:0]      tile_word_t;
  typedef logic [TILE_ADDR_W-1:0] tile_addr_t;

  // ------------------------------------------------
  // Commands, buffer requests, channel FSM
  // ------------------------------------------------
  typedef struct packed {
    shift_t shift;
  } quant_cmd_t;

  typedef struct packed {
    scale_t scale;
    shift_t shift;
  } dequant_cmd_t;

  typedef struct packed {
    logic       we;
    tile_addr_t addr;
    tile_word_t wdata;
  } tile_req_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    DRAIN,
    WAIT_LAST
  } chan_state_t;

endpackage

`default_nettype wire
